//--- hw/gpio.sv
// ----------------------------------------
// GPIO block with edge interrupt
// ----------------------------------------
`timescale 1ns/1ps
`include "soc_config.svh"

module gpio #(
  parameter int unsigned GpioCount = `GPIO_COUNT
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  obi_pkg::obi_req_t    req_i,
  output obi_pkg::obi_rsp_t    rsp_o,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,
  output logic                 irq_o
);
  import obi_pkg::*;
  import soc_pkg::*;

  logic [11:0]            offset;
  logic                   wr_en;
  logic [GpioCount-1:0]   sync1_q;
  logic [GpioCount-1:0]   sync2_q;
  logic [GpioCount-1:0]   prev_q;
  logic [GpioCount-1:0]   in_rise;
  logic [GpioCount-1:0]   dir_q;
  logic [GpioCount-1:0]   out_q;
  logic [GpioCount-1:0]   irq_en_q;
  logic [GpioCount-1:0]   status_q;
  logic [GpioCount-1:0]   status_clr;
  logic [`DATA_WIDTH-1:0] dir_new;
  logic [`DATA_WIDTH-1:0] out_new;
  logic [`DATA_WIDTH-1:0] en_new;
  logic [`DATA_WIDTH-1:0] clr_word;
  logic [`DATA_WIDTH-1:0] rd_data;
  logic [`DATA_WIDTH-1:0] rdata_q;
  logic                   rvalid_q;

  assign offset  = req_i.a.addr[11:0];
  assign wr_en   = req_i.req && req_i.a.we;
  assign in_rise = sync2_q & ~prev_q;

  // Byte-merged write values
  always_comb begin
    dir_new  = apply_be(`DATA_WIDTH'(dir_q), req_i.a.wdata, req_i.a.be);
    out_new  = apply_be(`DATA_WIDTH'(out_q), req_i.a.wdata, req_i.a.be);
    en_new   = apply_be(`DATA_WIDTH'(irq_en_q), req_i.a.wdata, req_i.a.be);
    clr_word = apply_be('0, req_i.a.wdata, req_i.a.be);
    status_clr = (wr_en && (offset == gpio_irq_status_offset)) ?
                 clr_word[GpioCount-1:0] : '0;
  end

  always_comb begin
    case (offset)
      gpio_dir_offset:        rd_data = `DATA_WIDTH'(dir_q);
      gpio_out_offset:        rd_data = `DATA_WIDTH'(out_q);
      gpio_in_offset:         rd_data = `DATA_WIDTH'(sync2_q);
      gpio_irq_status_offset: rd_data = `DATA_WIDTH'(status_q);
      gpio_irq_en_offset:     rd_data = `DATA_WIDTH'(irq_en_q);
      default:                rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
      dir_q    <= '0;
      out_q    <= '0;
      irq_en_q <= '0;
      status_q <= '0;
      rvalid_q <= 1'b0;
    end else begin
      // Two-flop input synchronizer
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      rvalid_q <= req_i.req;
      // New edges win over a clear in the same cycle
      status_q <= (status_q & ~status_clr) | in_rise;
      if (wr_en && (offset == gpio_dir_offset)) begin
        dir_q <= dir_new[GpioCount-1:0];
      end
      if (wr_en && (offset == gpio_out_offset)) begin
        out_q <= out_new[GpioCount-1:0];
      end
      if (wr_en && (offset == gpio_irq_en_offset)) begin
        irq_en_q <= en_new[GpioCount-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.a.we ? '0 : rd_data;
    end
  end

  always_comb begin
    rsp_o.gnt     = 1'b1;
    rsp_o.rvalid  = rvalid_q;
    rsp_o.r.rdata = rdata_q;
    rsp_o.r.err   = 1'b0;
  end

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync2_q;
  assign irq_o          = |(status_q & irq_en_q);

endmodule

//--- hw/obi_addr_demux.sv
// ----------------------------------------
// OBI address demultiplexer
// ----------------------------------------
`timescale 1ns/1ps
`include "soc_config.svh"

module obi_addr_demux #(
  parameter type         req_t    = obi_pkg::obi_req_t,
  parameter type         rsp_t    = obi_pkg::obi_rsp_t,
  parameter int unsigned NumPorts = 3,
  parameter soc_pkg::addr_rule_t [NumPorts-1:1] Rules = '0
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  req_t sbr_req_i,
  output rsp_t sbr_rsp_o,
  output req_t mgr_req_o [NumPorts],
  input  rsp_t mgr_rsp_i [NumPorts]
);

  localparam int unsigned MaxOut = `MAX_OUTSTANDING;
  localparam int unsigned IdxW   = (NumPorts > 1) ? $clog2(NumPorts) : 1;
  localparam int unsigned PtrW   = (MaxOut > 1) ? $clog2(MaxOut) : 1;
  localparam int unsigned CntW   = $clog2(MaxOut + 1);

  logic [IdxW-1:0]     sel_idx;
  logic [IdxW-1:0]     head_idx;
  logic [IdxW-1:0]     fifo_q [MaxOut];
  logic [PtrW-1:0]     wr_ptr_q;
  logic [PtrW-1:0]     rd_ptr_q;
  logic [CntW-1:0]     cnt_q;
  logic [CntW-1:0]     cnt_left;
  logic                push;
  logic                pop;
  logic                stall;
  logic [NumPorts-1:0] port_rvalid;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(MaxOut - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Address decode, unmatched goes to port 0
  always_comb begin
    sel_idx = '0;
    for (int r = 1; r < NumPorts; r++) begin
      if ((sbr_req_i.a.addr >= Rules[r].start_addr) &&
          (sbr_req_i.a.addr < Rules[r].end_addr)) begin
        sel_idx = Rules[r].idx[IdxW-1:0];
      end
    end
  end

  assign head_idx = fifo_q[rd_ptr_q];
  assign pop      = (cnt_q != '0) && mgr_rsp_i[head_idx].rvalid;
  assign cnt_left = cnt_q - CntW'(pop);

  // Hold off on a full FIFO or a switch to another port
  assign stall = (cnt_left == CntW'(MaxOut)) ||
                 ((cnt_left != '0) && (sel_idx != head_idx));
  assign push  = sbr_req_i.req && sbr_rsp_o.gnt;

  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      mgr_req_o[i]     = sbr_req_i;
      mgr_req_o[i].req = sbr_req_i.req && !stall && (sel_idx == IdxW'(i));
      port_rvalid[i]   = mgr_rsp_i[i].rvalid;
    end
    sbr_rsp_o        = mgr_rsp_i[head_idx];
    sbr_rsp_o.gnt    = sbr_req_i.req && !stall && mgr_rsp_i[sel_idx].gnt;
    sbr_rsp_o.rvalid = pop;
  end

  // ----------------------------------------
  // Outstanding index FIFO
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      cnt_q <= cnt_left + CntW'(push);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= sel_idx;
    end
  end

  // Subordinates answer only what was routed to them
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cnt_q == '0) |-> (port_rvalid == '0))
    else $error("rvalid with no outstanding request");

endmodule

//--- hw/obi_err_sbr.sv
// ----------------------------------------
// OBI error subordinate
// ----------------------------------------
`timescale 1ns/1ps
`include "soc_config.svh"

module obi_err_sbr (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  obi_pkg::obi_req_t req_i,
  output obi_pkg::obi_rsp_t rsp_o
);

  logic rvalid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  // Fixed error answer for reads and writes
  always_comb begin
    rsp_o.gnt     = 1'b1;
    rsp_o.rvalid  = rvalid_q;
    rsp_o.r.rdata = `ERR_RSP_DATA;
    rsp_o.r.err   = 1'b1;
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.rvalid |-> $past(req_i.req && rsp_o.gnt))
    else $error("error response without a granted request");

endmodule

//--- hw/obi_pkg.sv
// ----------------------------------------
// OBI bus types
// ----------------------------------------
`include "soc_config.svh"

package obi_pkg;

  // Address phase payload
  typedef struct packed {
    logic [`ADDR_WIDTH-1:0]   addr;
    logic                     we;
    logic [`DATA_WIDTH/8-1:0] be;
    logic [`DATA_WIDTH-1:0]   wdata;
  } obi_a_chan_t;

  // Response phase payload
  typedef struct packed {
    logic [`DATA_WIDTH-1:0] rdata;
    logic                   err;
  } obi_r_chan_t;

  typedef struct packed {
    logic        req;
    obi_a_chan_t a;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    obi_r_chan_t r;
  } obi_rsp_t;

  // Merge write data into a word under byte enables
  function automatic logic [`DATA_WIDTH-1:0] apply_be(
    input logic [`DATA_WIDTH-1:0]   old_data,
    input logic [`DATA_WIDTH-1:0]   new_data,
    input logic [`DATA_WIDTH/8-1:0] be
  );
    logic [`DATA_WIDTH-1:0] merged;
    merged = old_data;
    for (int i = 0; i < `DATA_WIDTH/8; i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = new_data[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

//--- hw/soc_config.svh
// ----------------------------------------
// SoC bus domain configuration
// ----------------------------------------
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// SRAM bank
`define SRAM_BASE      32'h1000_0000
`define SRAM_NUM_WORDS 256
`define SRAM_SIZE      (32'(`SRAM_NUM_WORDS) * 32'd4)

// Peripheral region, 64 KiB split into 4 KiB windows
`define PERIPH_BASE     32'h0300_0000
`define PERIPH_SIZE     32'h0001_0000
`define PERIPH_WIN_SIZE 32'h0000_1000
`define SOC_CTRL_BASE   (`PERIPH_BASE + 32'h0000_0000)
`define GPIO_BASE       (`PERIPH_BASE + 32'h0000_1000)

`define GPIO_COUNT      16
`define ERR_RSP_DATA    32'hBADCAB1E
`define MAX_OUTSTANDING 2

`endif

//--- hw/soc_ctrl_regs.sv
// ----------------------------------------
// SoC control registers
// ----------------------------------------
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_ctrl_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  obi_pkg::obi_req_t      req_i,
  output obi_pkg::obi_rsp_t      rsp_o,
  input  logic                   fetch_en_i,
  output logic [`ADDR_WIDTH-1:0] boot_addr_o,
  output logic                   fetch_enable_o
);
  import obi_pkg::*;
  import soc_pkg::*;

  logic [11:0]             offset;
  logic                    wr_en;
  logic [`ADDR_WIDTH-1:0]  boot_addr_q;
  logic                    fetch_en_q;
  logic [`DATA_WIDTH-1:0]  scratch_q;
  logic [`DATA_WIDTH-1:0]  rd_data;
  logic [`DATA_WIDTH-1:0]  rdata_q;
  logic                    rvalid_q;

  assign offset = req_i.a.addr[11:0];
  assign wr_en  = req_i.req && req_i.a.we;

  // Read mux, unknown offsets read zero
  always_comb begin
    case (offset)
      ctrl_bootaddr_offset: rd_data = boot_addr_q;
      ctrl_fetchen_offset:  rd_data = {{(`DATA_WIDTH-1){1'b0}}, fetch_en_q};
      ctrl_scratch_offset:  rd_data = scratch_q;
      default:              rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= `SRAM_BASE;
      fetch_en_q  <= 1'b0;
      scratch_q   <= '0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (wr_en) begin
        case (offset)
          ctrl_bootaddr_offset: boot_addr_q <= apply_be(boot_addr_q, req_i.a.wdata, req_i.a.be);
          ctrl_fetchen_offset: begin
            if (req_i.a.be[0]) begin
              fetch_en_q <= req_i.a.wdata[0];
            end
          end
          ctrl_scratch_offset:  scratch_q <= apply_be(scratch_q, req_i.a.wdata, req_i.a.be);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.a.we ? '0 : rd_data;
    end
  end

  always_comb begin
    rsp_o.gnt     = 1'b1;
    rsp_o.rvalid  = rvalid_q;
    rsp_o.r.rdata = rdata_q;
    rsp_o.r.err   = 1'b0;
  end

  assign boot_addr_o    = boot_addr_q;
  // Pin can start the core regardless of the register
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

//--- hw/soc_domain.sv
// ----------------------------------------
// SoC bus domain top level
// ----------------------------------------
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_domain (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   fetch_en_i,
  input  obi_pkg::obi_req_t      obi_req_i,
  output obi_pkg::obi_rsp_t      obi_rsp_o,
  input  logic [`GPIO_COUNT-1:0] gpio_i,
  output logic [`GPIO_COUNT-1:0] gpio_o,
  output logic [`GPIO_COUNT-1:0] gpio_out_en_o,
  output logic [`GPIO_COUNT-1:0] gpio_in_sync_o,
  output logic                   gpio_irq_o,
  output logic [`ADDR_WIDTH-1:0] boot_addr_o,
  output logic                   fetch_enable_o
);
  import obi_pkg::*;
  import soc_pkg::*;

  // Buses out of the demultiplexers, indexed as in the maps
  obi_req_t main_req   [num_main_ports];
  obi_rsp_t main_rsp   [num_main_ports];
  obi_req_t periph_req [num_periph_ports];
  obi_rsp_t periph_rsp [num_periph_ports];

  // ----------------------------------------
  // Main interconnect
  // ----------------------------------------
  obi_addr_demux #(
    .req_t    ( obi_req_t      ),
    .rsp_t    ( obi_rsp_t      ),
    .NumPorts ( num_main_ports ),
    .Rules    ( main_map       )
  ) u_main_demux (
    .clk_i,
    .rst_n_i,
    .sbr_req_i ( obi_req_i ),
    .sbr_rsp_o ( obi_rsp_o ),
    .mgr_req_o ( main_req  ),
    .mgr_rsp_i ( main_rsp  )
  );

  sram_bank u_sram (
    .clk_i,
    .rst_n_i,
    .req_i ( main_req[main_sram_idx] ),
    .rsp_o ( main_rsp[main_sram_idx] )
  );

  obi_err_sbr u_main_err (
    .clk_i,
    .rst_n_i,
    .req_i ( main_req[main_err_idx] ),
    .rsp_o ( main_rsp[main_err_idx] )
  );

  // ----------------------------------------
  // Peripherals
  // ----------------------------------------
  obi_addr_demux #(
    .req_t    ( obi_req_t        ),
    .rsp_t    ( obi_rsp_t        ),
    .NumPorts ( num_periph_ports ),
    .Rules    ( periph_map       )
  ) u_periph_demux (
    .clk_i,
    .rst_n_i,
    .sbr_req_i ( main_req[main_periph_idx] ),
    .sbr_rsp_o ( main_rsp[main_periph_idx] ),
    .mgr_req_o ( periph_req                ),
    .mgr_rsp_i ( periph_rsp                )
  );

  obi_err_sbr u_periph_err (
    .clk_i,
    .rst_n_i,
    .req_i ( periph_req[periph_err_idx] ),
    .rsp_o ( periph_rsp[periph_err_idx] )
  );

  soc_ctrl_regs u_soc_ctrl (
    .clk_i,
    .rst_n_i,
    .req_i          ( periph_req[periph_ctrl_idx] ),
    .rsp_o          ( periph_rsp[periph_ctrl_idx] ),
    .fetch_en_i,
    .boot_addr_o,
    .fetch_enable_o
  );

  gpio #(
    .GpioCount ( `GPIO_COUNT )
  ) u_gpio (
    .clk_i,
    .rst_n_i,
    .req_i          ( periph_req[periph_gpio_idx] ),
    .rsp_o          ( periph_rsp[periph_gpio_idx] ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .irq_o          ( gpio_irq_o )
  );

endmodule

//--- hw/soc_pkg.sv
// ----------------------------------------
// SoC address map and register offsets
// ----------------------------------------
`include "soc_config.svh"

package soc_pkg;

  // One decode rule, end address exclusive
  typedef struct packed {
    logic [2:0]             idx;
    logic [`ADDR_WIDTH-1:0] start_addr;
    logic [`ADDR_WIDTH-1:0] end_addr;
  } addr_rule_t;

  // ----------------------------------------
  // Main map, port 0 is the error port
  // ----------------------------------------
  localparam int unsigned num_main_ports  = 3;
  localparam int unsigned main_err_idx    = 0;
  localparam int unsigned main_sram_idx   = 1;
  localparam int unsigned main_periph_idx = 2;

  localparam addr_rule_t [num_main_ports-1:1] main_map = '{
    '{idx: 3'(main_periph_idx), start_addr: `PERIPH_BASE,
      end_addr: `PERIPH_BASE + `PERIPH_SIZE},
    '{idx: 3'(main_sram_idx), start_addr: `SRAM_BASE,
      end_addr: `SRAM_BASE + `SRAM_SIZE}
  };

  // ----------------------------------------
  // Peripheral map
  // ----------------------------------------
  localparam int unsigned num_periph_ports = 3;
  localparam int unsigned periph_err_idx   = 0;
  localparam int unsigned periph_ctrl_idx  = 1;
  localparam int unsigned periph_gpio_idx  = 2;

  localparam addr_rule_t [num_periph_ports-1:1] periph_map = '{
    '{idx: 3'(periph_gpio_idx), start_addr: `GPIO_BASE,
      end_addr: `GPIO_BASE + `PERIPH_WIN_SIZE},
    '{idx: 3'(periph_ctrl_idx), start_addr: `SOC_CTRL_BASE,
      end_addr: `SOC_CTRL_BASE + `PERIPH_WIN_SIZE}
  };

  // SoC control registers
  localparam logic [11:0] ctrl_bootaddr_offset = 12'h000;
  localparam logic [11:0] ctrl_fetchen_offset  = 12'h004;
  localparam logic [11:0] ctrl_scratch_offset  = 12'h008;

  // GPIO registers
  localparam logic [11:0] gpio_dir_offset        = 12'h000;
  localparam logic [11:0] gpio_out_offset        = 12'h004;
  localparam logic [11:0] gpio_in_offset         = 12'h008;
  localparam logic [11:0] gpio_irq_status_offset = 12'h00C;
  localparam logic [11:0] gpio_irq_en_offset     = 12'h010;

endpackage

//--- hw/sram_bank.sv
// ----------------------------------------
// SRAM bank with OBI port
// ----------------------------------------
`timescale 1ns/1ps
`include "soc_config.svh"

module sram_bank (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  obi_pkg::obi_req_t req_i,
  output obi_pkg::obi_rsp_t rsp_o
);
  import obi_pkg::*;

  localparam int unsigned WordAddrW = $clog2(`SRAM_NUM_WORDS);

  logic [`DATA_WIDTH-1:0] mem_q [`SRAM_NUM_WORDS];
  logic [WordAddrW-1:0]   word_addr;
  logic [`DATA_WIDTH-1:0] rdata_q;
  logic                   rvalid_q;

  // Word index sits right above the byte offset
  assign word_addr = req_i.a.addr[WordAddrW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.a.we) begin
        mem_q[word_addr] <= apply_be(mem_q[word_addr], req_i.a.wdata, req_i.a.be);
        rdata_q          <= '0;
      end else begin
        rdata_q <= mem_q[word_addr];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  always_comb begin
    rsp_o.gnt     = 1'b1;
    rsp_o.rvalid  = rvalid_q;
    rsp_o.r.rdata = rdata_q;
    rsp_o.r.err   = 1'b0;
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i.req && rsp_o.gnt && req_i.a.we) |-> (req_i.a.be != '0))
    else $error("write without byte enables");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SoC bus domain testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_soc_domain \
  -o tb_soc_domain 2>&1 | tee sim.log \
  && ./obj_dir/tb_soc_domain 2>&1 | tee -a sim.log \
  || { echo "Build or simulation returned an error status"; exit 1; }
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

//--- sim.f
+incdir+hw
hw/obi_pkg.sv
hw/soc_pkg.sv
hw/obi_addr_demux.sv
hw/sram_bank.sv
hw/obi_err_sbr.sv
hw/soc_ctrl_regs.sv
hw/gpio.sv
hw/soc_domain.sv
verif/tb_soc_domain.sv

//--- verif/tb_soc_domain.sv
// ----------------------------------------
// SoC bus domain testbench
// ----------------------------------------
`timescale 1ns/1ps
`include "soc_config.svh"

module tb_soc_domain;
  import obi_pkg::*;
  import soc_pkg::*;

  localparam int unsigned TimeoutCycles = 100;
  localparam int unsigned NumSramAddrs  = 16;

  logic                   clk;
  logic                   rst_n;
  logic                   fetch_en;
  obi_req_t               obi_req;
  obi_rsp_t               obi_rsp;
  logic [`GPIO_COUNT-1:0] gpio_in;
  logic [`GPIO_COUNT-1:0] gpio_out;
  logic [`GPIO_COUNT-1:0] gpio_out_en;
  logic [`GPIO_COUNT-1:0] gpio_in_sync;
  logic                   gpio_irq;
  logic [`ADDR_WIDTH-1:0] boot_addr;
  logic                   fetch_enable;

  // Reference model state
  logic [`DATA_WIDTH-1:0] sram_model [`SRAM_NUM_WORDS];
  logic [`ADDR_WIDTH-1:0] boot_model;
  logic                   fetch_model;
  logic [`DATA_WIDTH-1:0] scratch_model;
  logic [`GPIO_COUNT-1:0] dir_model;
  logic [`GPIO_COUNT-1:0] out_model;
  logic [`GPIO_COUNT-1:0] en_model;
  logic [`GPIO_COUNT-1:0] status_model;
  logic [`GPIO_COUNT-1:0] in_model;

  obi_r_chan_t exp_q [$];
  int unsigned n_issued;
  int unsigned n_checked;

  soc_domain uut (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .fetch_en_i     ( fetch_en     ),
    .obi_req_i      ( obi_req      ),
    .obi_rsp_o      ( obi_rsp      ),
    .gpio_i         ( gpio_in      ),
    .gpio_o         ( gpio_out     ),
    .gpio_out_en_o  ( gpio_out_en  ),
    .gpio_in_sync_o ( gpio_in_sync ),
    .gpio_irq_o     ( gpio_irq     ),
    .boot_addr_o    ( boot_addr    ),
    .fetch_enable_o ( fetch_enable )
  );

  always #2 clk = ~clk;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic [`DATA_WIDTH-1:0] byte_merge(
    input logic [`DATA_WIDTH-1:0]   old_word,
    input logic [`DATA_WIDTH-1:0]   new_word,
    input logic [`DATA_WIDTH/8-1:0] be
  );
    logic [`DATA_WIDTH-1:0] mask;
    for (int b = 0; b < `DATA_WIDTH/8; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // Expected response of one access and the model update of a write
  function automatic obi_r_chan_t ref_access(
    input logic [`ADDR_WIDTH-1:0]   addr,
    input logic                     we,
    input logic [`DATA_WIDTH/8-1:0] be,
    input logic [`DATA_WIDTH-1:0]   wdata
  );
    obi_r_chan_t rsp;
    logic [11:0] offset;
    int unsigned word;
    rsp.rdata = '0;
    rsp.err   = 1'b0;
    offset    = addr[11:0];
    if ((addr >= `SRAM_BASE) && (addr < `SRAM_BASE + 4 * `SRAM_NUM_WORDS)) begin
      word = (addr - `SRAM_BASE) >> 2;
      if (we) begin
        sram_model[word] = byte_merge(sram_model[word], wdata, be);
      end else begin
        rsp.rdata = sram_model[word];
      end
    end else if ((addr >= `SOC_CTRL_BASE) && (addr < `SOC_CTRL_BASE + 32'h1000)) begin
      if (we) begin
        case (offset)
          ctrl_bootaddr_offset: boot_model = byte_merge(boot_model, wdata, be);
          ctrl_fetchen_offset: begin
            if (be[0]) begin
              fetch_model = wdata[0];
            end
          end
          ctrl_scratch_offset: scratch_model = byte_merge(scratch_model, wdata, be);
          default: ;
        endcase
      end else begin
        case (offset)
          ctrl_bootaddr_offset: rsp.rdata = boot_model;
          ctrl_fetchen_offset:  rsp.rdata = `DATA_WIDTH'(fetch_model);
          ctrl_scratch_offset:  rsp.rdata = scratch_model;
          default:              rsp.rdata = '0;
        endcase
      end
    end else if ((addr >= `GPIO_BASE) && (addr < `GPIO_BASE + 32'h1000)) begin
      if (we) begin
        case (offset)
          gpio_dir_offset:
            dir_model = `GPIO_COUNT'(byte_merge(`DATA_WIDTH'(dir_model), wdata, be));
          gpio_out_offset:
            out_model = `GPIO_COUNT'(byte_merge(`DATA_WIDTH'(out_model), wdata, be));
          gpio_irq_en_offset:
            en_model = `GPIO_COUNT'(byte_merge(`DATA_WIDTH'(en_model), wdata, be));
          // Write one to clear
          gpio_irq_status_offset:
            status_model = status_model & ~`GPIO_COUNT'(byte_merge('0, wdata, be));
          default: ;
        endcase
      end else begin
        case (offset)
          gpio_dir_offset:        rsp.rdata = `DATA_WIDTH'(dir_model);
          gpio_out_offset:        rsp.rdata = `DATA_WIDTH'(out_model);
          gpio_in_offset:         rsp.rdata = `DATA_WIDTH'(in_model);
          gpio_irq_status_offset: rsp.rdata = `DATA_WIDTH'(status_model);
          gpio_irq_en_offset:     rsp.rdata = `DATA_WIDTH'(en_model);
          default:                rsp.rdata = '0;
        endcase
      end
    end else begin
      // Unmapped in the main map or inside the peripheral region
      rsp.rdata = `ERR_RSP_DATA;
      rsp.err   = 1'b1;
    end
    return rsp;
  endfunction

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_rsp(input string name, input obi_r_chan_t got, input obi_r_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got rdata 0x%h err 0x%h, expected rdata 0x%h err 0x%h",
                          name, got.rdata, got.err, exp.rdata, exp.err));
    end
  endtask

  task automatic check_pins(input string name, input logic [`GPIO_COUNT-1:0] got,
                            input logic [`GPIO_COUNT-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input logic [`ADDR_WIDTH-1:0] got,
                            input logic [`ADDR_WIDTH-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Every rvalid is matched against the oldest expected response
  always @(posedge clk) begin
    if (rst_n && obi_rsp.rvalid) begin
      if (exp_q.size() == 0) begin
        abort_run("A response arrived with no request outstanding");
      end else begin
        check_rsp("obi_rsp_o.r", obi_rsp.r, exp_q.pop_front());
        n_checked++;
      end
    end
  end

  // ----------------------------------------
  // Bus and pin drivers
  // ----------------------------------------
  task automatic issue(input logic [`ADDR_WIDTH-1:0] addr, input logic we,
                       input logic [`DATA_WIDTH/8-1:0] be, input logic [`DATA_WIDTH-1:0] wdata);
    int unsigned waited;
    @(negedge clk);
    obi_req.req     = 1'b1;
    obi_req.a.addr  = addr;
    obi_req.a.we    = we;
    obi_req.a.be    = be;
    obi_req.a.wdata = wdata;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TimeoutCycles) begin
        abort_run("Timed out waiting for the bus to grant a request");
      end
    end while (!obi_rsp.gnt);
    exp_q.push_back(ref_access(addr, we, be, wdata));
    n_issued++;
  endtask

  task automatic idle_bus();
    @(negedge clk);
    obi_req = '0;
  endtask

  // Ends on a falling edge so outputs can be sampled right after
  task automatic drain_rsp();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > TimeoutCycles) begin
        abort_run("Timed out waiting for outstanding responses");
      end
    end
    @(negedge clk);
  endtask

  task automatic drive_pins(input logic [`GPIO_COUNT-1:0] value);
    @(negedge clk);
    status_model = status_model | (value & ~in_model);
    in_model     = value;
    gpio_in      = value;
  endtask

  task automatic wait_irq(input logic level);
    int unsigned waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TimeoutCycles) begin
        abort_run("Timed out waiting for gpio_irq_o to reach its expected level");
      end
    end while (gpio_irq !== level);
    @(negedge clk);
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    logic [`ADDR_WIDTH-1:0] addrs [NumSramAddrs];
    logic [`GPIO_COUNT-1:0] irq_mask;
    logic [`GPIO_COUNT-1:0] rise;
    void'($urandom(32'h1d20_dc39));
    clk           = 1'b0;
    rst_n         = 1'b0;
    fetch_en      = 1'b0;
    obi_req       = '0;
    gpio_in       = '0;
    n_issued      = 0;
    n_checked     = 0;
    boot_model    = `SRAM_BASE;
    fetch_model   = 1'b0;
    scratch_model = '0;
    dir_model     = '0;
    out_model     = '0;
    en_model      = '0;
    status_model  = '0;
    in_model      = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset values and the fetch enable pin
    @(negedge clk);
    check_addr("boot_addr_o", boot_addr, `SRAM_BASE);
    check_bit("fetch_enable_o", fetch_enable, 1'b0);
    check_bit("gpio_irq_o", gpio_irq, 1'b0);
    check_pins("gpio_out_en_o", gpio_out_en, '0);
    check_bit("obi_rsp_o.rvalid", obi_rsp.rvalid, 1'b0);
    fetch_en = 1'b1;
    @(negedge clk);
    check_bit("fetch_enable_o", fetch_enable, 1'b1);
    fetch_en = 1'b0;
    @(negedge clk);
    check_bit("fetch_enable_o", fetch_enable, 1'b0);
    issue(`SOC_CTRL_BASE + ctrl_bootaddr_offset, 1'b0, 4'hF, '0);

    // SRAM writes with full words first so every byte is known
    for (int i = 0; i < NumSramAddrs; i++) begin
      addrs[i] = `SRAM_BASE + (32'($urandom_range(`SRAM_NUM_WORDS - 1)) << 2);
      issue(addrs[i], 1'b1, 4'hF, $urandom());
    end
    for (int i = 0; i < NumSramAddrs; i++) begin
      issue(addrs[i], 1'b1, 4'($urandom_range(15, 1)), $urandom());
    end
    for (int i = 0; i < NumSramAddrs; i++) begin
      issue(addrs[i], 1'b0, 4'h0, '0);
    end
    idle_bus();
    drain_rsp();

    // Unmapped addresses
    issue(32'h0000_0000, 1'b0, 4'h0, '0);
    issue(32'h2000_0040, 1'b1, 4'hF, $urandom());
    issue(`SRAM_BASE + 4 * `SRAM_NUM_WORDS, 1'b0, 4'h0, '0);
    issue(`PERIPH_BASE + 32'h2000, 1'b0, 4'h0, '0);
    issue(`PERIPH_BASE + 32'hF004, 1'b1, 4'h3, $urandom());
    idle_bus();
    drain_rsp();

    // SoC control registers
    issue(`SOC_CTRL_BASE + ctrl_fetchen_offset, 1'b1, 4'h1, 32'h1);
    issue(`SOC_CTRL_BASE + ctrl_bootaddr_offset, 1'b1, 4'hF, $urandom());
    issue(`SOC_CTRL_BASE + ctrl_scratch_offset, 1'b1, 4'hF, $urandom());
    issue(`SOC_CTRL_BASE + ctrl_scratch_offset, 1'b1, 4'b0110, $urandom());
    issue(`SOC_CTRL_BASE + ctrl_scratch_offset, 1'b0, 4'h0, '0);
    issue(`SOC_CTRL_BASE + ctrl_fetchen_offset, 1'b0, 4'h0, '0);
    issue(`SOC_CTRL_BASE + ctrl_bootaddr_offset, 1'b0, 4'h0, '0);
    issue(`SOC_CTRL_BASE + 32'h10, 1'b0, 4'h0, '0);
    idle_bus();
    drain_rsp();
    check_bit("fetch_enable_o", fetch_enable, fetch_model);
    check_addr("boot_addr_o", boot_addr, boot_model);

    // GPIO direction and output
    issue(`GPIO_BASE + gpio_dir_offset, 1'b1, 4'hF, $urandom());
    issue(`GPIO_BASE + gpio_out_offset, 1'b1, 4'h1, $urandom());
    issue(`GPIO_BASE + gpio_dir_offset, 1'b0, 4'h0, '0);
    issue(`GPIO_BASE + gpio_out_offset, 1'b0, 4'h0, '0);
    idle_bus();
    drain_rsp();
    check_pins("gpio_out_en_o", gpio_out_en, dir_model);
    check_pins("gpio_o", gpio_out, out_model);

    // Edge interrupt with bit 0 always enabled and rising
    irq_mask = `GPIO_COUNT'($urandom()) | `GPIO_COUNT'(1);
    issue(`GPIO_BASE + gpio_irq_en_offset, 1'b1, 4'hF, `DATA_WIDTH'(irq_mask));
    idle_bus();
    drain_rsp();
    rise = (`GPIO_COUNT'($urandom()) & irq_mask) | `GPIO_COUNT'(1);
    drive_pins(rise);
    wait_irq(|(status_model & en_model));
    check_pins("gpio_in_sync_o", gpio_in_sync, in_model);
    issue(`GPIO_BASE + gpio_irq_status_offset, 1'b0, 4'h0, '0);
    issue(`GPIO_BASE + gpio_in_offset, 1'b0, 4'h0, '0);
    issue(`GPIO_BASE + gpio_irq_status_offset, 1'b1, 4'hF, `DATA_WIDTH'(status_model));
    issue(`GPIO_BASE + gpio_irq_status_offset, 1'b0, 4'h0, '0);
    idle_bus();
    drain_rsp();
    wait_irq(|(status_model & en_model));

    drain_rsp();
    if (n_checked == n_issued) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      abort_run($sformatf("Only %0d of %0d responses were checked", n_checked, n_issued));
    end
  end

endmodule
